// File: hw/mpmc_pkg.sv
`default_nettype none

package mpmc_pkg;

	// ============================================================
	// Widths
	// ============================================================
	parameter int NUM_CH     = 4;
	parameter int DATA_WIDTH = 128;
	parameter int MASK_WIDTH = DATA_WIDTH / 8;
	parameter int ADDR_WIDTH = 32;
	parameter int AMO_WIDTH  = 64;
	parameter int LANE_BYTES = AMO_WIDTH / 8;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [MASK_WIDTH-1:0] mask_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [AMO_WIDTH-1:0]  amo_t;

	// Channel command, PLAIN is a read or write depending on we
	typedef enum logic [3:0] {
		PLAIN = 4'd0,
		ADD   = 4'd1,
		AND   = 4'd2,
		OR    = 4'd3,
		EOR   = 4'd4,
		MINU  = 4'd5,
		MAXU  = 4'd6,
		MIN   = 4'd7,
		MAX   = 4'd8
	} cmd_e;

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		READ,
		READ_WAIT,
		AMO_CALC,
		AMO_WRITE,
		ACK
	} state_e;

	// Memory user interface command codes
	parameter logic [2:0] APP_CMD_WRITE = 3'd0;
	parameter logic [2:0] APP_CMD_READ  = 3'd1;

endpackage

`default_nettype wire

// File: hw/mpmc_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// Granted request, latched by the arbiter for the whole transaction
interface mpmc_req_if import mpmc_pkg::*; #(
	parameter int NUM_CH = mpmc_pkg::NUM_CH
) ();
	localparam int PORT_W = $clog2(NUM_CH);

	logic [PORT_W-1:0] port;
	logic              we;
	cmd_e              cmd;
	addr_t             adr;
	data_t             wr_data;
	mask_t             sel;

	modport arbiter (output port, we, cmd, adr, wr_data, sel);

	modport control (input we, cmd);

	modport datapath (input we, cmd, adr, wr_data, sel);

endinterface

`default_nettype wire

// File: hw/mpmc_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mpmc_port_arbiter import mpmc_pkg::*; #(
	parameter int NUM_CH = mpmc_pkg::NUM_CH
) (
	input  wire logic              mem_ui_clk,
	input  wire logic              mem_ui_rst,
	input  wire logic [NUM_CH-1:0] ch_cyc,
	input  wire logic [NUM_CH-1:0] ch_we,
	input  wire cmd_e [NUM_CH-1:0] ch_cmd,
	input  wire addr_t [NUM_CH-1:0] ch_adr,
	input  wire data_t [NUM_CH-1:0] ch_wr_data,
	input  wire mask_t [NUM_CH-1:0] ch_sel,
	input  wire logic              grant_take,
	input  wire logic              done,
	output logic [NUM_CH-1:0]      ch_ack,
	mpmc_req_if.arbiter            req
);
	localparam int PORT_W = $clog2(NUM_CH);

	logic [PORT_W-1:0] pick;

	// Search downward so the nearest requester after the last grant wins
	always_comb begin
		int idx;
		pick = req.port;
		for (int i = NUM_CH; i >= 1; i--) begin
			idx = (int'(req.port) + i) % NUM_CH;
			if (ch_cyc[idx])
				pick = PORT_W'(idx);
		end
	end

	// Port starts at the last channel so channel 0 is served first
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			req.port <= PORT_W'(NUM_CH - 1);
			ch_ack <= '0;
		end else begin
			if (grant_take)
				req.port <= pick;
			ch_ack <= '0;
			if (done)
				ch_ack[req.port] <= 1'b1;
		end
	end

	always_ff @(posedge mem_ui_clk) begin
		if (grant_take) begin
			req.we      <= ch_we[pick];
			req.cmd     <= ch_cmd[pick];
			req.adr     <= ch_adr[pick];
			req.wr_data <= ch_wr_data[pick];
			req.sel     <= ch_sel[pick];
		end
	end

endmodule

`default_nettype wire

// File: hw/mpmc_state_machine.sv
`timescale 1ns/1ps
`default_nettype none

module mpmc_state_machine import mpmc_pkg::*; #(
	parameter int NUM_CH = mpmc_pkg::NUM_CH
) (
	input  wire logic              mem_ui_clk,
	input  wire logic              mem_ui_rst,
	input  wire logic [NUM_CH-1:0] ch_cyc,
	input  wire logic              app_rdy,
	input  wire logic              app_wdf_rdy,
	input  wire logic              app_rd_data_valid,
	mpmc_req_if.control            req,
	output state_e                 state,
	output logic                   grant_take,
	output logic                   done
);
	state_e next_state;
	logic   granted;
	logic   ack_gap;
	logic   armed;
	logic   cmd_ok;
	logic   wdf_ok;
	logic   cmd_acc;
	logic   wdf_acc;
	logic   write_phase;

	// The acked channel still holds cyc in the cycle after ACK
	assign grant_take = (state == IDLE) && !granted && !ack_gap && (|ch_cyc);
	assign done = (state == ACK);

	// The driver raises its strobes one cycle after the state is entered
	assign write_phase = (state == WRITE) || (state == AMO_WRITE);
	assign cmd_acc = armed && !cmd_ok && app_rdy;
	assign wdf_acc = armed && !wdf_ok && app_wdf_rdy && write_phase;

	always_comb begin
		next_state = state;
		case (state)
			IDLE:
				if (granted)
					next_state = req.we ? WRITE : READ;
			WRITE, AMO_WRITE:
				if ((cmd_ok || cmd_acc) && (wdf_ok || wdf_acc))
					next_state = ACK;
			READ:
				if (cmd_acc)
					next_state = READ_WAIT;
			READ_WAIT:
				if (app_rd_data_valid)
					next_state = (req.cmd == PLAIN) ? ACK : AMO_CALC;
			AMO_CALC:
				next_state = AMO_WRITE;
			ACK:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			state <= IDLE;
			granted <= 1'b0;
			ack_gap <= 1'b0;
			armed <= 1'b0;
			cmd_ok <= 1'b0;
			wdf_ok <= 1'b0;
		end else begin
			state <= next_state;
			granted <= grant_take;
			ack_gap <= (state == ACK);
			armed <= (next_state == state);
			if (next_state != state) begin
				cmd_ok <= 1'b0;
				wdf_ok <= 1'b0;
			end else begin
				cmd_ok <= cmd_ok | cmd_acc;
				wdf_ok <= wdf_ok | wdf_acc;
			end
		end
	end

	// ============================================================
	// Assertions
	// ============================================================
	a_state_known: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		!$isunknown(state));

	a_done_single: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		done |=> !done);

	// Only one read is in flight, so data must find us waiting
	a_rd_valid_wait: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		app_rd_data_valid |-> state == READ_WAIT);

endmodule

`default_nettype wire

// File: hw/mpmc_amo_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mpmc_amo_unit import mpmc_pkg::*; (
	input  wire logic   mem_ui_clk,
	input  wire logic   mem_ui_rst,
	input  wire state_e state,
	input  wire data_t  app_rd_data,
	input  wire logic   app_rd_data_valid,
	mpmc_req_if.datapath req,
	output data_t       rd_data,
	output data_t       amo_beat
);
	logic lane;
	amo_t opa;
	amo_t opb;
	amo_t res;

	// Read beat, also the old value returned for an atomic
	always_ff @(posedge mem_ui_clk) begin
		if (app_rd_data_valid)
			rd_data <= app_rd_data;
	end

	// Address bit 3 picks the upper or lower 64-bit lane
	assign lane = req.adr[3];
	assign opa = rd_data[lane*AMO_WIDTH +: AMO_WIDTH];
	assign opb = req.wr_data[lane*AMO_WIDTH +: AMO_WIDTH];

	always_comb begin
		case (req.cmd)
			ADD:     res = opa + opb;
			AND:     res = opa & opb;
			OR:      res = opa | opb;
			EOR:     res = opa ^ opb;
			MINU:    res = (opa < opb) ? opa : opb;
			MAXU:    res = (opa > opb) ? opa : opb;
			MIN:     res = ($signed(opa) < $signed(opb)) ? opa : opb;
			MAX:     res = ($signed(opa) > $signed(opb)) ? opa : opb;
			default: res = opa;
		endcase
	end

	// Result goes back into its lane, the other lane keeps the old bytes
	always_ff @(posedge mem_ui_clk) begin
		if (state == AMO_CALC) begin
			amo_beat <= rd_data;
			amo_beat[lane*AMO_WIDTH +: AMO_WIDTH] <= res;
		end
	end

	// ============================================================
	// Assertions
	// ============================================================
	a_amo_no_we: assert property (@(posedge mem_ui_clk) disable iff (mem_ui_rst)
		(state != IDLE && req.cmd != PLAIN) |-> !req.we);

endmodule

`default_nettype wire

// File: hw/mpmc_app_driver.sv
`timescale 1ns/1ps
`default_nettype none

module mpmc_app_driver import mpmc_pkg::*; (
	input  wire logic   mem_ui_clk,
	input  wire logic   mem_ui_rst,
	input  wire state_e state,
	input  wire logic   app_rdy,
	input  wire logic   app_wdf_rdy,
	input  wire data_t  amo_beat,
	mpmc_req_if.datapath req,
	output logic        app_en,
	output logic [2:0]  app_cmd,
	output addr_t       app_addr,
	output data_t       app_wdf_data,
	output mask_t       app_wdf_mask,
	output logic        app_wdf_wren,
	output logic        app_wdf_end
);
	logic  cmd_state;
	logic  wr_state;
	logic  cmd_sent;
	logic  wdf_sent;
	mask_t wmask;
	data_t wbeat;
	data_t wfill;

	assign cmd_state = (state == READ) || (state == WRITE) || (state == AMO_WRITE);
	assign wr_state = (state == WRITE) || (state == AMO_WRITE);

	// Atomic writes open only the eight bytes of the chosen lane
	always_comb begin
		if (state == AMO_WRITE) begin
			wbeat = amo_beat;
			wmask = req.adr[3] ? {{LANE_BYTES{1'b0}}, {LANE_BYTES{1'b1}}}
			                   : {{LANE_BYTES{1'b1}}, {LANE_BYTES{1'b0}}};
		end else begin
			wbeat = req.wr_data;
			wmask = ~req.sel;
		end
	end

	// Skipped bytes carry all ones on the bus
	always_comb begin
		for (int i = 0; i < MASK_WIDTH; i++)
			wfill[i*8 +: 8] = wmask[i] ? 8'hFF : wbeat[i*8 +: 8];
	end

	// ============================================================
	// Command and write-data strobes
	// ============================================================
	always_ff @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			app_en <= 1'b0;
			cmd_sent <= 1'b0;
			app_wdf_wren <= 1'b0;
			wdf_sent <= 1'b0;
		end else begin
			if (cmd_state) begin
				cmd_sent <= cmd_sent | (app_en & app_rdy);
				app_en <= !cmd_sent && !(app_en && app_rdy);
			end else begin
				cmd_sent <= 1'b0;
				app_en <= 1'b0;
			end
			if (wr_state) begin
				wdf_sent <= wdf_sent | (app_wdf_wren & app_wdf_rdy);
				app_wdf_wren <= !wdf_sent && !(app_wdf_wren && app_wdf_rdy);
			end else begin
				wdf_sent <= 1'b0;
				app_wdf_wren <= 1'b0;
			end
		end
	end

	// Fields freeze while their strobe is presented
	always_ff @(posedge mem_ui_clk) begin
		if (cmd_state && !app_en) begin
			app_cmd <= (state == READ) ? APP_CMD_READ : APP_CMD_WRITE;
			app_addr <= {req.adr[ADDR_WIDTH-1:4], 4'b0000};
		end
		if (wr_state && !app_wdf_wren) begin
			app_wdf_data <= wfill;
			app_wdf_mask <= wmask;
		end
	end

	// Single-beat transfers, every beat is the last
	assign app_wdf_end = app_wdf_wren;

endmodule

`default_nettype wire

// File: hw/mpmc_top.sv
`timescale 1ns/1ps
`default_nettype none

module mpmc_top import mpmc_pkg::*; #(
	parameter int NUM_CH = mpmc_pkg::NUM_CH
) (
	input  wire logic              mem_ui_clk,
	input  wire logic              mem_ui_rst,
	// Channels
	input  wire logic [NUM_CH-1:0] ch_cyc,
	input  wire logic [NUM_CH-1:0] ch_we,
	input  wire cmd_e [NUM_CH-1:0] ch_cmd,
	input  wire addr_t [NUM_CH-1:0] ch_adr,
	input  wire data_t [NUM_CH-1:0] ch_wr_data,
	input  wire mask_t [NUM_CH-1:0] ch_sel,
	output logic [NUM_CH-1:0]      ch_ack,
	output data_t                  rd_data,
	// Memory user interface
	output logic                   app_en,
	output logic [2:0]             app_cmd,
	output addr_t                  app_addr,
	output data_t                  app_wdf_data,
	output mask_t                  app_wdf_mask,
	output logic                   app_wdf_wren,
	output logic                   app_wdf_end,
	input  wire logic              app_rdy,
	input  wire logic              app_wdf_rdy,
	input  wire data_t             app_rd_data,
	input  wire logic              app_rd_data_valid
);
	state_e state;
	logic   grant_take;
	logic   done;
	data_t  amo_beat;

	mpmc_req_if #(.NUM_CH(NUM_CH)) req ();

	mpmc_port_arbiter #(.NUM_CH(NUM_CH)) u_arbiter (
		.mem_ui_clk (mem_ui_clk),
		.mem_ui_rst (mem_ui_rst),
		.ch_cyc     (ch_cyc),
		.ch_we      (ch_we),
		.ch_cmd     (ch_cmd),
		.ch_adr     (ch_adr),
		.ch_wr_data (ch_wr_data),
		.ch_sel     (ch_sel),
		.grant_take (grant_take),
		.done       (done),
		.ch_ack     (ch_ack),
		.req        (req.arbiter)
	);

	mpmc_state_machine #(.NUM_CH(NUM_CH)) u_fsm (
		.mem_ui_clk        (mem_ui_clk),
		.mem_ui_rst        (mem_ui_rst),
		.ch_cyc            (ch_cyc),
		.app_rdy           (app_rdy),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data_valid (app_rd_data_valid),
		.req               (req.control),
		.state             (state),
		.grant_take        (grant_take),
		.done              (done)
	);

	mpmc_amo_unit u_amo (
		.mem_ui_clk        (mem_ui_clk),
		.mem_ui_rst        (mem_ui_rst),
		.state             (state),
		.app_rd_data       (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid),
		.req               (req.datapath),
		.rd_data           (rd_data),
		.amo_beat          (amo_beat)
	);

	mpmc_app_driver u_driver (
		.mem_ui_clk   (mem_ui_clk),
		.mem_ui_rst   (mem_ui_rst),
		.state        (state),
		.app_rdy      (app_rdy),
		.app_wdf_rdy  (app_wdf_rdy),
		.amo_beat     (amo_beat),
		.req          (req.datapath),
		.app_en       (app_en),
		.app_cmd      (app_cmd),
		.app_addr     (app_addr),
		.app_wdf_data (app_wdf_data),
		.app_wdf_mask (app_wdf_mask),
		.app_wdf_wren (app_wdf_wren),
		.app_wdf_end  (app_wdf_end)
	);

endmodule

`default_nettype wire

// File: verification/tb_mpmc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mpmc import mpmc_pkg::*; ();

	localparam int NUM_TXN     = 400;
	localparam int CYCLE_LIMIT = NUM_TXN * 40;
	localparam int WIN_BYTES   = 64;
	localparam int PORT_W      = $clog2(NUM_CH);

	typedef logic [PORT_W-1:0] port_t;

	logic                mem_ui_clk;
	logic                mem_ui_rst;
	logic [NUM_CH-1:0]   ch_cyc;
	logic [NUM_CH-1:0]   ch_we;
	cmd_e [NUM_CH-1:0]   ch_cmd;
	addr_t [NUM_CH-1:0]  ch_adr;
	data_t [NUM_CH-1:0]  ch_wr_data;
	mask_t [NUM_CH-1:0]  ch_sel;
	logic [NUM_CH-1:0]   ch_ack;
	data_t               rd_data;
	logic                app_en;
	logic [2:0]          app_cmd;
	addr_t               app_addr;
	data_t               app_wdf_data;
	mask_t               app_wdf_mask;
	logic                app_wdf_wren;
	logic                app_wdf_end;
	logic                app_rdy;
	logic                app_wdf_rdy;
	data_t               app_rd_data;
	logic                app_rd_data_valid;

	// Memory model bytes and reference beats over the shared window
	logic [7:0] mem_bytes [0:WIN_BYTES-1];
	data_t      ref_beats [0:WIN_BYTES/16-1];
	int         start_cyc [0:NUM_CH-1];
	int         cycle;
	int         rst_cycles;
	int         issued;
	int         done_cnt;
	int         cmd_cnt;
	int         wdf_cnt;
	int         last_port;
	int         rd_delay;
	int         seed_val;
	logic [2:0] last_cmd;
	addr_t      last_addr;
	addr_t      wr_addr;
	addr_t      rd_addr;
	data_t      wdf_data;
	mask_t      wdf_mask;
	logic       wr_cmd_pend;
	logic       wr_data_pend;
	logic       rd_pend;

	mpmc_top #(.NUM_CH(NUM_CH)) UUT (
		.mem_ui_clk        (mem_ui_clk),
		.mem_ui_rst        (mem_ui_rst),
		.ch_cyc            (ch_cyc),
		.ch_we             (ch_we),
		.ch_cmd            (ch_cmd),
		.ch_adr            (ch_adr),
		.ch_wr_data        (ch_wr_data),
		.ch_sel            (ch_sel),
		.ch_ack            (ch_ack),
		.rd_data           (rd_data),
		.app_en            (app_en),
		.app_cmd           (app_cmd),
		.app_addr          (app_addr),
		.app_wdf_data      (app_wdf_data),
		.app_wdf_mask      (app_wdf_mask),
		.app_wdf_wren      (app_wdf_wren),
		.app_wdf_end       (app_wdf_end),
		.app_rdy           (app_rdy),
		.app_wdf_rdy       (app_wdf_rdy),
		.app_rd_data       (app_rd_data),
		.app_rd_data_valid (app_rd_data_valid)
	);

	initial begin
		mem_ui_clk = 1'b0;
		forever #2 mem_ui_clk = ~mem_ui_clk;
	end

	// ============================================================
	// Reporting and compare tasks
	// ============================================================
	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_mask(input string name, input mask_t got, input mask_t exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_port(input string name, input port_t got, input port_t exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_cmd(input string name, input logic [2:0] got, input logic [2:0] exp);
		if (got !== exp)
			fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_quiet();
		if (app_en !== 1'b0 || app_wdf_wren !== 1'b0 || ch_ack !== '0)
			fail_run($sformatf("Error: app_en %h app_wdf_wren %h ch_ack %h expected 0",
				app_en, app_wdf_wren, ch_ack));
	endtask

	// ============================================================
	// Reference model helpers
	// ============================================================
	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 59 + 90);
	endfunction

	function automatic data_t mem_beat(input addr_t a);
		data_t beat;
		for (int b = 0; b < MASK_WIDTH; b++)
			beat[b*8 +: 8] = mem_bytes[int'(a[5:4]) * 16 + b];
		return beat;
	endfunction

	function automatic amo_t amo_result(input cmd_e op, input amo_t a, input amo_t b);
		logic signed [AMO_WIDTH-1:0] sa;
		logic signed [AMO_WIDTH-1:0] sb;
		amo_t r;
		sa = a;
		sb = b;
		case (op)
			ADD:     r = a + b;
			AND:     r = a & b;
			OR:      r = a | b;
			EOR:     r = a ^ b;
			MINU:    r = (b < a) ? b : a;
			MAXU:    r = (b > a) ? b : a;
			MIN:     r = (sb < sa) ? b : a;
			MAX:     r = (sb > sa) ? b : a;
			default: r = a;
		endcase
		return r;
	endfunction

	// Memory side: command and write beat capture, read return, random stalls
	task automatic model_memory();
		int base;
		app_rd_data_valid <= 1'b0;
		if (rd_pend) begin
			rd_delay--;
			if (rd_delay == 0) begin
				app_rd_data_valid <= 1'b1;
				app_rd_data <= mem_beat(rd_addr);
				rd_pend = 1'b0;
			end
		end
		if (app_wdf_end !== app_wdf_wren)
			fail_run("app_wdf_end does not follow app_wdf_wren on a single-beat write");
		if (app_en && app_rdy) begin
			cmd_cnt++;
			last_cmd = app_cmd;
			last_addr = app_addr;
			if (app_cmd == APP_CMD_READ) begin
				rd_pend = 1'b1;
				rd_delay = 2 + int'($urandom % 7);
				rd_addr = app_addr;
			end else begin
				wr_cmd_pend = 1'b1;
				wr_addr = app_addr;
			end
		end
		if (app_wdf_wren && app_wdf_rdy) begin
			wdf_cnt++;
			wdf_data = app_wdf_data;
			wdf_mask = app_wdf_mask;
			wr_data_pend = 1'b1;
		end
		// Command and data may be accepted in either order
		if (wr_cmd_pend && wr_data_pend) begin
			base = int'(wr_addr[5:4]) * 16;
			for (int b = 0; b < MASK_WIDTH; b++)
				if (!wdf_mask[b])
					mem_bytes[base + b] = wdf_data[b*8 +: 8];
			wr_cmd_pend = 1'b0;
			wr_data_pend = 1'b0;
		end
		app_rdy <= ($urandom % 4) != 0;
		app_wdf_rdy <= ($urandom % 4) != 0;
	endtask

	task automatic check_transaction(input int n);
		int    beat;
		int    lane;
		logic  is_amo;
		logic  is_wr;
		data_t old_beat;
		data_t new_beat;
		data_t exp_bus;
		mask_t exp_mask;
		amo_t  res;
		beat = int'(ch_adr[n][5:4]);
		lane = int'(ch_adr[n][3]);
		old_beat = ref_beats[beat];
		new_beat = old_beat;
		exp_bus = '1;
		exp_mask = '0;
		is_amo = (ch_cmd[n] != PLAIN);
		is_wr = is_amo || ch_we[n];
		check_addr("app_addr", last_addr, {ch_adr[n][ADDR_WIDTH-1:4], 4'h0});
		if (is_amo) begin
			res = amo_result(ch_cmd[n], old_beat[lane*AMO_WIDTH +: AMO_WIDTH],
				ch_wr_data[n][lane*AMO_WIDTH +: AMO_WIDTH]);
			new_beat[lane*AMO_WIDTH +: AMO_WIDTH] = res;
			exp_bus[lane*AMO_WIDTH +: AMO_WIDTH] = res;
			for (int b = 0; b < MASK_WIDTH; b++)
				exp_mask[b] = ((b / LANE_BYTES) != lane);
			check_data("rd_data", rd_data, old_beat);
		end else if (ch_we[n]) begin
			for (int b = 0; b < MASK_WIDTH; b++) begin
				if (ch_sel[n][b]) begin
					new_beat[b*8 +: 8] = ch_wr_data[n][b*8 +: 8];
					exp_bus[b*8 +: 8] = ch_wr_data[n][b*8 +: 8];
				end
			end
			exp_mask = ~ch_sel[n];
		end else begin
			check_data("rd_data", rd_data, old_beat);
		end
		// An atomic issues a read command and then a write command
		check_count("accepted commands", cmd_cnt, is_amo ? 2 : 1);
		check_count("accepted write beats", wdf_cnt, is_wr ? 1 : 0);
		check_cmd("app_cmd", last_cmd, is_wr ? APP_CMD_WRITE : APP_CMD_READ);
		if (is_wr) begin
			check_mask("app_wdf_mask", wdf_mask, exp_mask);
			check_data("app_wdf_data", wdf_data, exp_bus);
		end
		ref_beats[beat] = new_beat;
		check_data("memory beat", mem_beat(ch_adr[n]), new_beat);
	endtask

	task automatic serve_acks();
		int   m;
		int   exp_port;
		logic found;
		if ($countones(ch_ack) > 1)
			fail_run("More than one channel acked in the same cycle");
		for (int n = 0; n < NUM_CH; n++) begin
			if (ch_ack[n]) begin
				if (!ch_cyc[n])
					fail_run($sformatf("Ack on channel %0d without a pending request", n));
				// First channel after the last grant that surely requested before n
				exp_port = n;
				found = 1'b0;
				for (int k = 1; k <= NUM_CH; k++) begin
					m = (last_port + k) % NUM_CH;
					if (!found && (m == n || (ch_cyc[m] && start_cyc[m] <= start_cyc[n]))) begin
						exp_port = m;
						found = 1'b1;
					end
				end
				check_port("acked channel", port_t'(n), port_t'(exp_port));
				check_transaction(n);
				ch_cyc[n] <= 1'b0;
				last_port = n;
				done_cnt++;
				cmd_cnt = 0;
				wdf_cnt = 0;
			end
		end
	endtask

	task automatic launch_requests();
		int kind;
		for (int n = 0; n < NUM_CH; n++) begin
			if (!ch_cyc[n] && issued < NUM_TXN && ($urandom % 2) == 0) begin
				// About 40% writes, 40% reads and 20% atomics
				kind = int'($urandom % 10);
				ch_cyc[n] <= 1'b1;
				ch_we[n] <= (kind < 4);
				ch_cmd[n] <= (kind < 8) ? PLAIN : cmd_e'(4'(1 + $urandom % 8));
				ch_adr[n] <= addr_t'($urandom % WIN_BYTES);
				ch_wr_data[n] <= {$urandom, $urandom, $urandom, $urandom};
				ch_sel[n] <= mask_t'($urandom);
				start_cyc[n] = cycle;
				issued++;
			end
		end
	endtask

	always @(posedge mem_ui_clk) begin
		if (mem_ui_rst) begin
			rst_cycles++;
			if (rst_cycles > 1)
				check_quiet();
		end else begin
			if (cycle == 0)
				check_quiet();
			cycle++;
			if (cycle > CYCLE_LIMIT)
				fail_run($sformatf("Timeout after %0d cycles with %0d of %0d transactions acked",
					cycle, done_cnt, NUM_TXN));
			model_memory();
			serve_acks();
			launch_requests();
		end
	end

	initial begin
		seed_val = $urandom(74862);
		ch_cyc = '0;
		ch_we = '0;
		ch_cmd = {NUM_CH{PLAIN}};
		ch_adr = '0;
		ch_wr_data = '0;
		ch_sel = '0;
		app_rdy = 1'b1;
		app_wdf_rdy = 1'b1;
		app_rd_data = '0;
		app_rd_data_valid = 1'b0;
		cycle = 0;
		rst_cycles = 0;
		issued = 0;
		done_cnt = 0;
		cmd_cnt = 0;
		wdf_cnt = 0;
		last_port = NUM_CH - 1;
		rd_delay = 0;
		rd_pend = 1'b0;
		wr_cmd_pend = 1'b0;
		wr_data_pend = 1'b0;
		for (int i = 0; i < NUM_CH; i++)
			start_cyc[i] = 0;
		for (int a = 0; a < WIN_BYTES; a++) begin
			mem_bytes[a] = fill_byte(a);
			ref_beats[a / 16][(a % 16)*8 +: 8] = fill_byte(a);
		end
		mem_ui_rst = 1'b1;
		repeat (16) @(posedge mem_ui_clk);
		mem_ui_rst <= 1'b0;
		wait (done_cnt == NUM_TXN);
		repeat (20) @(posedge mem_ui_clk);
		if (cmd_cnt != 0 || wdf_cnt != 0 || ch_cyc != '0 || ch_ack != '0) begin
			fail_run("Memory or channel traffic seen after the last ack");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
hw/mpmc_pkg.sv
hw/mpmc_req_if.sv
hw/mpmc_port_arbiter.sv
hw/mpmc_state_machine.sv
hw/mpmc_amo_unit.sv
hw/mpmc_app_driver.sv
hw/mpmc_top.sv
verification/tb_mpmc.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mpmc -f verilog.f

# A failing run still prints its output, the search below decides the status
output=$(./obj_dir/Vtb_mpmc || true)
echo "$output"

echo "$output" | grep -q '^>>> PASS$'
